//--- common/armCtrlPkg.sv
`default_nettype none

package armCtrlPkg;

  // Data-processing opcodes in bits 24:21
  typedef enum logic [3:0] {
    opAnd = 4'h0, opEor = 4'h1, opSub = 4'h2, opRsb = 4'h3,
    opAdd = 4'h4, opAdc = 4'h5, opSbc = 4'h6, opRsc = 4'h7,
    opTst = 4'h8, opTeq = 4'h9, opCmp = 4'ha, opCmn = 4'hb,
    opOrr = 4'hc, opMov = 4'hd, opBic = 4'he, opMvn = 4'hf
  } aluOpT;

  // Condition field in bits 31:28
  typedef enum logic [3:0] {
    condEq = 4'h0, condNe = 4'h1, condCs = 4'h2, condCc = 4'h3,
    condMi = 4'h4, condPl = 4'h5, condVs = 4'h6, condVc = 4'h7,
    condHi = 4'h8, condLs = 4'h9, condGe = 4'ha, condLt = 4'hb,
    condGt = 4'hc, condLe = 4'hd, condAl = 4'he, condNv = 4'hf
  } condT;

  typedef enum logic [2:0] {
    dataImm,
    dataReg,
    multiply,
    load,
    store,
    branch,
    illegal
  } instrClassT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  typedef struct packed {
    logic       aluSrc;
    logic       memToReg;
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       pcSrc;
    logic       multSelect;
    logic [1:0] flagWrite;   // [1] NZ, [0] CV
    aluOpT      aluControl;
  } decodeCtrlT;

  typedef struct packed {
    logic       aluSrc;
    logic       memToReg;
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       pcSrc;
    logic [1:0] flagWrite;
    aluOpT      aluControl;
    condT       cond;
  } execCtrlT;

  typedef struct packed {
    logic memWrite;
    logic memToReg;
    logic regWrite;
    logic pcSrc;
  } memCtrlT;

  typedef struct packed {
    logic memToReg;
    logic regWrite;
    logic pcSrc;
  } wbCtrlT;

  // Instruction field positions
  localparam int condLsb  = 28;
  localparam int classLsb = 25;   // Bits 27:25 select the class
  localparam int iBit     = 25;   // Immediate flag
  localparam int opLsb    = 21;
  localparam int sBit     = 20;   // S bit, L bit for memory ops
  localparam int rnLsb    = 16;   // Also Rd of multiply
  localparam int rdLsb    = 12;
  localparam int rmLsb    = 0;

  localparam logic [3:0] multPattern = 4'b1001;   // Bits 7:4 of MUL/MLA
  localparam logic [3:0] pcRegNum    = 4'd15;

endpackage

`default_nettype wire

//--- controller/controller.sv
`default_nettype none

module controller (
  input  wire logic                   clk,
  input  wire logic                   rstN,
  input  wire logic [31:0]            instrD,
  input  wire armCtrlPkg::decodeCtrlT ctrlD,
  input  wire logic                   stallD,
  input  wire logic                   flushE,
  input  wire logic                   condExE,
  output armCtrlPkg::execCtrlT        exCtrlE,
  output logic [31:0]                 instrE,
  output logic                        branchTakenE,
  output armCtrlPkg::memCtrlT         memCtrlM,
  output armCtrlPkg::wbCtrlT          wbCtrlW,
  output logic [2:0]                  pcSrcPending   // [0] decode, [1] execute, [2] memory
);

  import armCtrlPkg::*;

  execCtrlT execNext;
  memCtrlT  memNext;
  wbCtrlT   wbNext;
  logic     pcSrcGatedE;

  // Decode to execute controls without multSelect
  always_comb begin
    execNext.aluSrc     = ctrlD.aluSrc;
    execNext.memToReg   = ctrlD.memToReg;
    execNext.regWrite   = ctrlD.regWrite;
    execNext.memWrite   = ctrlD.memWrite;
    execNext.branch     = ctrlD.branch;
    execNext.pcSrc      = ctrlD.pcSrc;
    execNext.flagWrite  = ctrlD.flagWrite;
    execNext.aluControl = ctrlD.aluControl;
    execNext.cond       = condT'(instrD[condLsb +: 4]);
  end

  always_ff @(posedge clk) begin
    if (!rstN || flushE) begin
      exCtrlE <= '0;   // Bubble
    end else if (!stallD) begin
      exCtrlE <= execNext;
    end
  end

  // Execute-stage instruction word, source of the load destination
  always_ff @(posedge clk) begin
    if (!stallD) begin
      instrE <= instrD;
    end
  end

  // Condition gating of writes and branch
  assign pcSrcGatedE  = exCtrlE.pcSrc & condExE;
  assign branchTakenE = exCtrlE.branch & condExE;

  always_comb begin
    memNext.memWrite = exCtrlE.memWrite & condExE;
    memNext.memToReg = exCtrlE.memToReg;
    memNext.regWrite = exCtrlE.regWrite & condExE;
    memNext.pcSrc    = pcSrcGatedE;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      memCtrlM <= '0;
    end else begin
      memCtrlM <= memNext;
    end
  end

  always_comb begin
    wbNext.memToReg = memCtrlM.memToReg;
    wbNext.regWrite = memCtrlM.regWrite;
    wbNext.pcSrc    = memCtrlM.pcSrc;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wbCtrlW <= '0;
    end else begin
      wbCtrlW <= wbNext;
    end
  end

  // PC writes still in flight for the hazard unit
  assign pcSrcPending = {memCtrlM.pcSrc, pcSrcGatedE, ctrlD.pcSrc};

  // Decoder never marks one instruction as both load and store
  memExclusiveA: assert property (@(posedge clk) disable iff (!rstN)
    !(memCtrlM.memWrite && memCtrlM.memToReg))
    else $error("Memory stage shows load and store together");

endmodule

`default_nettype wire

//--- runSim.sh
#!/bin/sh
# Compile and run with Verilator, pass only if the log holds the pass message
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tbCtrlTop \
  -o simCtrl > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/simCtrl > sim.log 2>&1 ; cat sim.log
grep -q "SIMULATION PASSED" sim.log && exit 0 || exit 1

//--- sim/ctrlStim.txt
# name instrD flagsE(nzcv, of the instruction in execute) then expected:
# regWriteW memWriteM branchTakenE stallD flushE aluControl prevFlags(nzcv), all hex
nop0        e1000000 0 0 0 0 0 0 8 0
addsDec     e2932001 0 0 0 0 0 0 8 0
addsExec    e1000000 4 0 0 0 0 0 4 0
addsMem     e1000000 0 0 0 0 0 0 8 4
addsWb      e1000000 0 1 0 0 0 0 8 4
addeqDec    00854006 0 0 0 0 0 0 8 4
addeqExec   e1000000 0 0 0 0 0 0 4 4
cmpDec      e3530000 0 0 0 0 0 0 8 4
cmpExec     e1000000 0 1 0 0 0 0 a 4
addeqSkip   00854006 0 0 0 0 0 0 8 0
streqSkip   05887004 0 0 0 0 0 0 4 0
streqExec   e1000000 0 0 0 0 0 0 4 0
strDec      e5887004 0 0 0 0 0 0 8 0
strExec     e1000000 0 0 0 0 0 0 4 0
strMem      e1000000 0 0 1 0 0 0 8 0
ldrDec      e5981000 0 0 0 0 0 0 8 0
useStall    e0819000 0 0 0 0 1 1 4 0
useHeld     e0819000 0 0 0 0 0 0 0 0
useExec     e1000000 0 1 0 0 0 0 4 0
useMem      e1000000 0 0 0 0 0 0 8 0
bDec        ea000004 0 1 0 0 0 0 8 0
bTaken      e1000000 0 0 0 1 0 1 4 0
bBubble     e1000000 0 0 0 0 0 0 0 0
beqDec      0a000004 0 0 0 0 0 0 8 0
beqNotTaken e1000000 0 0 0 0 0 0 4 0
drain0      e1000000 0 0 0 0 0 0 8 0
drain1      e1000000 0 0 0 0 0 0 8 0
drain2      e1000000 0 0 0 0 0 0 8 0

//--- sim/tbCtrlTop.sv
`default_nettype none

module tbCtrlTop;

  timeunit 1ns;
  timeprecision 100ps;

  import armCtrlPkg::*;

  localparam logic [31:0] nopInstr = 32'he1000000;   // TST r0, r0 without S writes nothing
  localparam int clkPeriod = 8;

  logic        clk;
  logic        rstN;
  logic [31:0] instrD;
  flagsT       flagsE;

  logic [1:0]  regSrcD;
  logic [1:0]  immSrcD;
  execCtrlT    exCtrlOut;
  logic        branchTakenE;
  flagsT       prevFlagsE;
  logic [31:0] instrE;
  memCtrlT     memCtrlM;
  wbCtrlT      wbCtrlW;
  logic        stallF;
  logic        stallD;
  logic        flushD;
  logic        flushE;
  logic        illegalD;

  // One entry per stim line
  string       stimName[$];
  logic [31:0] stimInstr[$];
  logic [3:0]  stimFlags[$];
  logic [4:0]  stimExpect[$];   // regWriteW, memWriteM, branchTakenE, stallD, flushE
  logic [3:0]  stimAlu[$];
  logic [3:0]  stimPrevFlags[$];
  logic        stimLoaded;

  ctrlTop uut (
    .clk          (clk),
    .rstN         (rstN),
    .instrD       (instrD),
    .flagsE       (flagsE),
    .regSrcD      (regSrcD),
    .immSrcD      (immSrcD),
    .exCtrlOut    (exCtrlOut),
    .branchTakenE (branchTakenE),
    .prevFlagsE   (prevFlagsE),
    .instrE       (instrE),
    .memCtrlM     (memCtrlM),
    .wbCtrlW      (wbCtrlW),
    .stallF       (stallF),
    .stallD       (stallD),
    .flushD       (flushD),
    .flushE       (flushE),
    .illegalD     (illegalD)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  task automatic checkValue(input string testName, input string what,
                            input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERR %s %s expected %h actual %h", testName, what, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1, "Output mismatch");
    end
  endtask

  task automatic stopOnBadStim(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "Stimulus problem");
  endtask

  task automatic loadStim();
    int          fd;
    int          count;
    string       lineText;
    string       nameTmp;
    logic [31:0] instrTmp;
    logic [3:0]  flagsTmp;
    logic [3:0]  aluTmp;
    logic [3:0]  prevTmp;
    logic        rwTmp;
    logic        mwTmp;
    logic        brTmp;
    logic        stTmp;
    logic        flTmp;
    fd = $fopen("sim/ctrlStim.txt", "r");
    if (fd == 0) stopOnBadStim("Cannot open the stimulus file sim/ctrlStim.txt");
    while (!$feof(fd)) begin
      lineText = "";
      void'($fgets(lineText, fd));
      if (lineText.len() < 2 || lineText[0] == "#") continue;   // Blank or comment
      count = $sscanf(lineText, "%s %h %h %h %h %h %h %h %h %h", nameTmp, instrTmp, flagsTmp,
                      rwTmp, mwTmp, brTmp, stTmp, flTmp, aluTmp, prevTmp);
      if (count != 10) stopOnBadStim({"Malformed stimulus line: ", lineText});
      stimName.push_back(nameTmp);
      stimInstr.push_back(instrTmp);
      stimFlags.push_back(flagsTmp);
      stimExpect.push_back({rwTmp, mwTmp, brTmp, stTmp, flTmp});
      stimAlu.push_back(aluTmp);
      stimPrevFlags.push_back(prevTmp);
    end
    $fclose(fd);
    if (stimName.size() == 0) stopOnBadStim("The stimulus file holds no test lines");
  endtask

  // Everything that must read zero right after reset
  task automatic checkResetState();
    checkValue("reset", "memCtrlM", 32'(4'b0000), 32'(memCtrlM));
    checkValue("reset", "wbCtrlW", 32'(3'b000), 32'(wbCtrlW));
    checkValue("reset", "exRegWrite", 32'(1'b0), 32'(exCtrlOut.regWrite));
    checkValue("reset", "exMemWrite", 32'(1'b0), 32'(exCtrlOut.memWrite));
    checkValue("reset", "exPcSrc", 32'(1'b0), 32'(exCtrlOut.pcSrc));
    checkValue("reset", "exFlagWrite", 32'(2'b00), 32'(exCtrlOut.flagWrite));
    checkValue("reset", "branchTakenE", 32'(1'b0), 32'(branchTakenE));
    checkValue("reset", "strobes", 32'(4'b0000), 32'({stallF, stallD, flushD, flushE}));
    checkValue("reset", "prevFlagsE", 32'(4'b0000), 32'(prevFlagsE));
  endtask

  task automatic checkLine(input int idx);
    string testName;
    testName = stimName[idx];
    checkValue(testName, "regWriteW", 32'(stimExpect[idx][4]), 32'(wbCtrlW.regWrite));
    checkValue(testName, "memWriteM", 32'(stimExpect[idx][3]), 32'(memCtrlM.memWrite));
    checkValue(testName, "branchTakenE", 32'(stimExpect[idx][2]), 32'(branchTakenE));
    checkValue(testName, "stallD", 32'(stimExpect[idx][1]), 32'(stallD));
    checkValue(testName, "flushE", 32'(stimExpect[idx][0]), 32'(flushE));
    checkValue(testName, "aluControl", 32'(stimAlu[idx]), 32'(exCtrlOut.aluControl));
    checkValue(testName, "prevFlagsE", 32'(stimPrevFlags[idx]), 32'(prevFlagsE));
    checkValue(testName, "illegalD", 32'(1'b0), 32'(illegalD));   // Supported classes only

    // Load-use stalls fetch too, a taken branch flushes decode
    if (stimExpect[idx][1])
      checkValue(testName, "stallF", 32'(1'b1), 32'(stallF));
    if (stimExpect[idx][2])
      checkValue(testName, "flushD", 32'(1'b1), 32'(flushD));

    // Previous line enters execute unless it was stalled or flushed
    if (idx == 0)
      checkValue(testName, "instrE", nopInstr, instrE);
    else if (!stimExpect[idx - 1][1] && !stimExpect[idx - 1][0])
      checkValue(testName, "instrE", stimInstr[idx - 1], instrE);
  endtask

  // Watchdog sized from the stim length
  initial begin
    int timeLimit;
    wait (stimLoaded === 1'b1);
    timeLimit = stimName.size() * clkPeriod + 200;
    #(timeLimit);
    $display("Timeout, the run did not finish in %0d ns", timeLimit);
    $display("SIMULATION FAILED");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    rstN       = 1'b0;
    instrD     = nopInstr;
    flagsE     = '0;
    stimLoaded = 1'b0;
    loadStim();
    stimLoaded = 1'b1;

    repeat (8) @(posedge clk);
    #1;
    rstN = 1'b1;
    #6;
    checkResetState();

    for (int i = 0; i < stimName.size(); i++) begin
      @(posedge clk);
      #1;
      instrD = stimInstr[i];
      flagsE = stimFlags[i];
      #6;   // Just before the next edge
      checkLine(i);
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/condUnit.sv
`default_nettype none

module condUnit (
  input  wire logic                clk,
  input  wire logic                rstN,
  input  wire armCtrlPkg::condT    cond,
  input  wire logic [1:0]          flagWrite,
  input  wire armCtrlPkg::flagsT   flagsE,
  output logic                     condExE,
  output armCtrlPkg::flagsT        prevFlags
);

  import armCtrlPkg::*;

  flagsT flagsQ;   // Stored NZCV
  logic  geFlag;

  assign geFlag = (flagsQ.n == flagsQ.v);

  always_comb begin
    case (cond)
      condEq: condExE = flagsQ.z;
      condNe: condExE = ~flagsQ.z;
      condCs: condExE = flagsQ.c;
      condCc: condExE = ~flagsQ.c;
      condMi: condExE = flagsQ.n;
      condPl: condExE = ~flagsQ.n;
      condVs: condExE = flagsQ.v;
      condVc: condExE = ~flagsQ.v;
      condHi: condExE = flagsQ.c & ~flagsQ.z;
      condLs: condExE = ~flagsQ.c | flagsQ.z;
      condGe: condExE = geFlag;
      condLt: condExE = ~geFlag;
      condGt: condExE = ~flagsQ.z & geFlag;
      condLe: condExE = flagsQ.z | ~geFlag;
      condAl: condExE = 1'b1;
      condNv: condExE = 1'b0;   // Never
    endcase
  end

  // Updated at the end of execute per field group
  always_ff @(posedge clk) begin
    if (!rstN) begin
      flagsQ <= '0;
    end else if (condExE) begin
      if (flagWrite[1]) begin
        flagsQ.n <= flagsE.n;
        flagsQ.z <= flagsE.z;
      end
      if (flagWrite[0]) begin
        flagsQ.c <= flagsE.c;
        flagsQ.v <= flagsE.v;
      end
    end
  end

  assign prevFlags = flagsQ;

  alwaysExecA: assert property (@(posedge clk) disable iff (!rstN)
    (cond == condAl) |-> condExE)
    else $error("AL instruction not executed");

endmodule

`default_nettype wire

//--- source/ctrlTop.sv
`default_nettype none

module ctrlTop (
  input  wire logic                 clk,
  input  wire logic                 rstN,
  input  wire logic [31:0]          instrD,
  input  wire armCtrlPkg::flagsT    flagsE,
  output logic [1:0]                regSrcD,
  output logic [1:0]                immSrcD,
  output armCtrlPkg::execCtrlT      exCtrlOut,
  output logic                      branchTakenE,
  output armCtrlPkg::flagsT         prevFlagsE,
  output logic [31:0]               instrE,
  output armCtrlPkg::memCtrlT       memCtrlM,
  output armCtrlPkg::wbCtrlT        wbCtrlW,
  output logic                      stallF,
  output logic                      stallD,
  output logic                      flushD,
  output logic                      flushE,
  output logic                      illegalD
);

  import armCtrlPkg::*;

  decodeCtrlT ctrlD;
  logic       condExE;
  logic [2:0] pcSrcPending;

  instrDecoder uDecoder (
    .instrD   (instrD),
    .ctrlD    (ctrlD),
    .regSrcD  (regSrcD),
    .immSrcD  (immSrcD),
    .illegalD (illegalD)
  );

  controller uController (
    .clk          (clk),
    .rstN         (rstN),
    .instrD       (instrD),
    .ctrlD        (ctrlD),
    .stallD       (stallD),
    .flushE       (flushE),
    .condExE      (condExE),
    .exCtrlE      (exCtrlOut),
    .instrE       (instrE),
    .branchTakenE (branchTakenE),
    .memCtrlM     (memCtrlM),
    .wbCtrlW      (wbCtrlW),
    .pcSrcPending (pcSrcPending)
  );

  condUnit uCond (
    .clk       (clk),
    .rstN      (rstN),
    .cond      (exCtrlOut.cond),
    .flagWrite (exCtrlOut.flagWrite),
    .flagsE    (flagsE),
    .condExE   (condExE),
    .prevFlags (prevFlagsE)
  );

  hazardUnit uHazard (
    .clk          (clk),
    .rstN         (rstN),
    .instrD       (instrD),
    .memToRegE    (exCtrlOut.memToReg),
    .destRegE     (instrE[rdLsb +: 4]),   // Load destination
    .pcSrcPending (pcSrcPending),
    .stallF       (stallF),
    .stallD       (stallD),
    .flushD       (flushD),
    .flushE       (flushE)
  );

endmodule

`default_nettype wire

//--- source/hazardUnit.sv
`default_nettype none

module hazardUnit (
  input  wire logic        clk,
  input  wire logic        rstN,
  input  wire logic [31:0] instrD,
  input  wire logic        memToRegE,
  input  wire logic [3:0]  destRegE,
  input  wire logic [2:0]  pcSrcPending,   // [0] decode, [1] execute, [2] memory
  output logic             stallF,
  output logic             stallD,
  output logic             flushD,
  output logic             flushE
);

  import armCtrlPkg::*;

  logic rnMatch;
  logic rmMatch;
  logic ldStall;
  logic pcWritePending;

  // Load in execute feeding Rn or Rm of decode
  assign rnMatch = (destRegE == instrD[rnLsb +: 4]);
  assign rmMatch = (destRegE == instrD[rmLsb +: 4]);
  assign ldStall = memToRegE && (rnMatch || rmMatch);

  assign pcWritePending = |pcSrcPending;

  assign stallF = ldStall | pcWritePending;
  assign stallD = ldStall;

  // Stall wins, the held instruction may itself be the PC writer
  assign flushD = pcWritePending & ~ldStall;

  // Bubble after a load, or redirect when execute writes the PC
  assign flushE = ldStall | pcSrcPending[1];

  noStallFlushA: assert property (@(posedge clk) disable iff (!rstN)
    !(stallD && flushD))
    else $error("Decode stalled and flushed together");

  // The bubble in execute clears memToRegE, so a load-use stall is one cycle
  singleStallA: assert property (@(posedge clk) disable iff (!rstN)
    stallD |=> !stallD)
    else $error("Load-use stall longer than one cycle");

endmodule

`default_nettype wire

//--- source/instrDecoder.sv
`default_nettype none

module instrDecoder (
  input  wire logic [31:0]           instrD,
  output armCtrlPkg::decodeCtrlT     ctrlD,
  output logic [1:0]                 regSrcD,
  output logic [1:0]                 immSrcD,
  output logic                       illegalD
);

  import armCtrlPkg::*;

  instrClassT instrClass;
  logic [3:0] destReg;
  logic       isDataProc;

  // Main decoder, class from bits 27:25 and 7:4
  always_comb begin
    case (instrD[classLsb +: 3])
      3'b000:         instrClass = (instrD[7:4] == multPattern) ? multiply : dataReg;
      3'b001:         instrClass = dataImm;
      3'b010, 3'b011: instrClass = instrD[sBit] ? load : store;
      3'b101:         instrClass = branch;
      default:        instrClass = illegal;   // LDM/STM, coprocessor, SWI
    endcase
  end

  assign isDataProc = (instrClass == dataImm) || (instrClass == dataReg);

  // MUL writes Rd in bits 19:16
  assign destReg = (instrClass == multiply) ? instrD[rnLsb +: 4] : instrD[rdLsb +: 4];

  always_comb begin
    ctrlD    = '0;
    regSrcD  = 2'b00;
    immSrcD  = 2'b00;
    illegalD = 1'b0;

    case (instrClass)
      dataImm: begin
        ctrlD.aluSrc   = 1'b1;
        ctrlD.regWrite = 1'b1;
      end
      dataReg: ctrlD.regWrite = 1'b1;
      multiply: begin
        ctrlD.regWrite   = 1'b1;
        ctrlD.multSelect = 1'b1;   // Result from the multiplier
      end
      load: begin
        immSrcD        = 2'b01;   // 12-bit offset
        ctrlD.aluSrc   = ~instrD[iBit];
        ctrlD.memToReg = 1'b1;
        ctrlD.regWrite = 1'b1;
      end
      store: begin
        regSrcD        = 2'b10;   // Rd read as store data
        immSrcD        = 2'b01;
        ctrlD.aluSrc   = ~instrD[iBit];
        ctrlD.memWrite = 1'b1;
      end
      branch: begin
        regSrcD      = 2'b01;     // PC as base
        immSrcD      = 2'b10;     // 24-bit word offset
        ctrlD.aluSrc = 1'b1;
        ctrlD.branch = 1'b1;
      end
      default: illegalD = 1'b1;
    endcase

    // ALU decoder
    if (isDataProc) begin
      ctrlD.aluControl = aluOpT'(instrD[opLsb +: 4]);
      ctrlD.flagWrite  = {2{instrD[sBit]}};
      if (ctrlD.aluControl inside {opTst, opTeq, opCmp, opCmn})
        ctrlD.regWrite = 1'b0;   // Flags only
    end else begin
      ctrlD.aluControl = opAdd;    // Address and target arithmetic
      ctrlD.flagWrite  = 2'b00;
    end

    ctrlD.pcSrc = ((destReg == pcRegNum) && ctrlD.regWrite) || ctrlD.branch;
  end

endmodule

`default_nettype wire

//--- sources.f
common/armCtrlPkg.sv
source/instrDecoder.sv
source/condUnit.sv
source/hazardUnit.sv
controller/controller.sv
source/ctrlTop.sv
sim/tbCtrlTop.sv
